/* design/kicker_pkg.sv */
/* kicker board glue package
   memory map, register bits, widths and mixer gain */
`default_nettype none

package kicker_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 8;

    // sound widths, both signed
    localparam int snd_w = 11;
    localparam int mix_w = 16;

    // addr[15:14] value of the low 16 KB, anything else is ROM
    localparam logic [1:0] rom_base_bits = 2'b00;

    // 2 KB pages, addr[13:11]
    localparam logic [2:0] io_page      = 3'd0;
    localparam logic [2:0] tidata2_page = 3'd1;
    localparam logic [2:0] tidata1_page = 3'd2;
    localparam logic [2:0] color_page   = 3'd3;
    localparam logic [2:0] vscr_page    = 3'd4;
    localparam logic [2:0] obj2_page    = 3'd5;
    localparam logic [2:0] obj1_page    = 3'd6;
    localparam logic [2:0] vram_page    = 3'd7;

    // I/O page split, addr[10:8]
    localparam logic [2:0] iow_sub     = 3'd0; // 1 was the watchdog
    localparam logic [2:0] intshow_sub = 3'd2;
    localparam logic [2:0] ti2_sub     = 3'd3;
    localparam logic [2:0] ti1_sub     = 3'd4;
    localparam logic [2:0] dip2_sub    = 3'd5;
    localparam logic [2:0] dip3_sub    = 3'd6;
    localparam logic [2:0] ior_sub     = 3'd7;

    // control register bits
    localparam int ctl_flip_bit = 0;
    localparam int ctl_nmi_bit  = 1;
    localparam int ctl_irq_bit  = 2;

    // tone amplitude per attenuation step
    localparam int amp_step = 32;

    // mixer gain 1.5 = 3 >> 1
    localparam int mix_gain_num   = 3;
    localparam int mix_gain_shift = 1;

endpackage

`default_nettype wire

/* design/kicker_decode.sv */
/* kicker address decoder
   turns 6809 bus cycles into chip selects */
`timescale 1ns/1ns
`default_nettype none

module kicker_decode (
    input  wire [kicker_pkg::addr_w-1:0] addr,
    input  wire                          rnw,
    input  wire                          vma,
    output logic                         rom_cs,
    output logic                         iow_cs,
    output logic                         intshow_cs,
    output logic                         ti1_cs,
    output logic                         ti2_cs,
    output logic                         dip2_cs,
    output logic                         dip3_cs,
    output logic                         ior_cs,
    output logic                         tidata1_cs,
    output logic                         tidata2_cs,
    output logic                         color_cs,
    output logic                         vscr_cs,
    output logic                         obj1_cs,
    output logic                         obj2_cs,
    output logic                         vram_cs
);
    import kicker_pkg::*;

    logic low_area;

    assign low_area = vma && (addr[15:14] == rom_base_bits);
    assign rom_cs   = vma && rnw && (addr[15:14] != rom_base_bits); // 4000-ffff, reads only

    always_comb begin
        iow_cs     = 1'b0;
        intshow_cs = 1'b0;
        ti1_cs     = 1'b0;
        ti2_cs     = 1'b0;
        dip2_cs    = 1'b0;
        dip3_cs    = 1'b0;
        ior_cs     = 1'b0;
        tidata1_cs = 1'b0;
        tidata2_cs = 1'b0;
        color_cs   = 1'b0;
        vscr_cs    = 1'b0;
        obj1_cs    = 1'b0;
        obj2_cs    = 1'b0;
        vram_cs    = 1'b0;
        if (low_area) begin
            case (addr[13:11])
                io_page: begin
                    case (addr[10:8])
                        iow_sub:     iow_cs     = 1'b1;
                        intshow_sub: intshow_cs = 1'b1;
                        ti2_sub:     ti2_cs     = 1'b1;
                        ti1_sub:     ti1_cs     = 1'b1;
                        dip2_sub:    dip2_cs    = 1'b1;
                        dip3_sub:    dip3_cs    = 1'b1;
                        ior_sub:     ior_cs     = 1'b1;
                        default: ; // unused slot
                    endcase
                end
                tidata2_page: tidata2_cs = 1'b1;
                tidata1_page: tidata1_cs = 1'b1;
                color_page:   color_cs   = 1'b1;
                vscr_page:    vscr_cs    = 1'b1; // vertical scroll
                obj2_page:    obj2_cs    = 1'b1;
                obj1_page:    obj1_cs    = 1'b1;
                vram_page:    vram_cs    = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/kicker_readback.sv */
/* kicker read-back
   cabinet byte formatting and registered CPU read mux */
`timescale 1ns/1ns
`default_nettype none

module kicker_readback (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [1:0]                    addr,
    input  wire                          rom_cs,
    input  wire                          vram_cs,
    input  wire                          intshow_cs,
    input  wire                          obj1_cs,
    input  wire                          obj2_cs,
    input  wire                          ior_cs,
    input  wire                          dip2_cs,
    input  wire                          dip3_cs,
    input  wire [kicker_pkg::data_w-1:0] rom_data,
    input  wire [kicker_pkg::data_w-1:0] vram_dout,
    input  wire [kicker_pkg::data_w-1:0] vscr_dout,
    input  wire [kicker_pkg::data_w-1:0] obj_dout,
    input  wire [1:0]                    start_button,
    input  wire [1:0]                    coin_input,
    input  wire [5:0]                    joystick1,
    input  wire [5:0]                    joystick2,
    input  wire                          service,
    input  wire [kicker_pkg::data_w-1:0] dipsw_a,
    input  wire [kicker_pkg::data_w-1:0] dipsw_b,
    input  wire [3:0]                    dipsw_c,
    output logic [kicker_pkg::data_w-1:0] cpu_din
);
    import kicker_pkg::*;

    logic [data_w-1:0] cabinet;

    // joystick bits are swapped in pairs on the board
    always_comb begin
        case (addr)
            2'd0: cabinet = {3'b111, start_button, service, coin_input};
            2'd1: cabinet = {2'b11, joystick1[5:4], joystick1[2], joystick1[3],
                             joystick1[0], joystick1[1]};
            2'd2: cabinet = {2'b11, joystick2[5:4], joystick2[2], joystick2[3],
                             joystick2[0], joystick2[1]};
            default: cabinet = dipsw_a;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 8'hff;
        end else begin
            if (rom_cs)
                cpu_din <= rom_data;
            else if (vram_cs)
                cpu_din <= vram_dout;
            else if (intshow_cs)
                cpu_din <= vscr_dout; // raster count from the scroll chip
            else if (obj1_cs || obj2_cs)
                cpu_din <= obj_dout;
            else if (ior_cs)
                cpu_din <= cabinet;
            else if (dip2_cs)
                cpu_din <= dipsw_b;
            else if (dip3_cs)
                cpu_din <= {4'hf, dipsw_c};
            else
                cpu_din <= 8'hff; // open bus
        end
    end

endmodule

`default_nettype wire

/* design/kicker_irq.sv */
/* kicker interrupt control
   control and palette registers, edge triggered IRQ and NMI */
`timescale 1ns/1ns
`default_nettype none

module kicker_irq (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cpu_cen,
    input  wire                          rnw,
    input  wire                          iow_cs,
    input  wire                          color_cs,
    input  wire [kicker_pkg::data_w-1:0] cpu_dout,
    input  wire                          lvbl,
    input  wire                          v16,
    input  wire                          dip_pause,
    output logic                         flip,
    output logic [2:0]                   pal_sel,
    output logic                         irq_n,
    output logic                         nmi_n
);
    import kicker_pkg::*;

    logic irq_clrn, nmi_clrn;
    logic irq_trig, nmi_trig;
    logic irq_prev, nmi_prev;
    logic irq_q, nmi_q;

    assign irq_trig = ~lvbl & dip_pause; // vblank start, unless paused
    assign nmi_trig = v16;

    // control and palette writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            irq_clrn <= 1'b0;
            nmi_clrn <= 1'b0;
            pal_sel  <= 3'd0;
        end else if (cpu_cen && !rnw) begin
            if (iow_cs) begin
                flip     <= cpu_dout[ctl_flip_bit];
                nmi_clrn <= cpu_dout[ctl_nmi_bit];
                irq_clrn <= cpu_dout[ctl_irq_bit];
            end
            if (color_cs)
                pal_sel <= cpu_dout[2:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_prev <= 1'b0;
            nmi_prev <= 1'b0;
            irq_q    <= 1'b0;
            nmi_q    <= 1'b0;
        end else begin
            irq_prev <= irq_trig;
            nmi_prev <= nmi_trig;
            // clear bit low holds the flip-flop off
            if (!irq_clrn)
                irq_q <= 1'b0;
            else if (irq_trig && !irq_prev)
                irq_q <= 1'b1;
            if (!nmi_clrn)
                nmi_q <= 1'b0;
            else if (nmi_trig && !nmi_prev)
                nmi_q <= 1'b1;
        end
    end

    assign irq_n = ~irq_q;
    assign nmi_n = ~nmi_q;

endmodule

`default_nettype wire

/* design/kicker_psg.sv */
/* kicker tone chip
   one square channel with period and attenuation registers */
`timescale 1ns/1ns
`default_nettype none

module kicker_psg (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                clk_en,
    input  wire                                wr,
    input  wire [kicker_pkg::data_w-1:0]       din,
    output logic signed [kicker_pkg::snd_w-1:0] sound
);
    import kicker_pkg::*;

    logic [9:0]              period;
    logic [9:0]              cnt;
    logic [3:0]              att;
    logic                    phase;
    logic signed [snd_w-1:0] amp;

    // register writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            period <= 10'd0;
            att    <= 4'hf; // silent
        end else if (clk_en && wr) begin
            if (din[7]) begin
                case (din[6:4])
                    3'd0:    period[3:0] <= din[3:0];
                    3'd1:    att         <= din[3:0];
                    default: ; // noise and other channels not built
                endcase
            end else begin
                period[9:4] <= din[5:0];
            end
        end
    end

    // half period of exactly `period` enables, 0 wraps to 1024
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= 10'd0;
            phase <= 1'b0;
        end else if (clk_en) begin
            if (cnt == 10'd0) begin
                cnt   <= period - 10'd1;
                phase <= ~phase;
            end else begin
                cnt <= cnt - 10'd1;
            end
        end
    end

    assign amp   = snd_w'((4'd15 - att) * amp_step);
    assign sound = phase ? amp : -amp;

endmodule

`default_nettype wire

/* design/kicker_sound.sv */
/* kicker sound
   data latches, two tone chips and the gain mixer */
`timescale 1ns/1ns
`default_nettype none

module kicker_sound (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 ti1_cen,
    input  wire                                 ti2_cen,
    input  wire                                 ti1_cs,
    input  wire                                 ti2_cs,
    input  wire                                 tidata1_cs,
    input  wire                                 tidata2_cs,
    input  wire [kicker_pkg::data_w-1:0]        cpu_dout,
    output logic signed [kicker_pkg::mix_w-1:0] snd,
    output logic                                sample
);
    import kicker_pkg::*;

    logic [data_w-1:0]       ti1_data, ti2_data;
    logic signed [snd_w-1:0] ti1_snd, ti2_snd;
    logic signed [mix_w-1:0] sum;

    // latches load whenever selected, no cpu_cen
    always_ff @(posedge clk) begin
        if (tidata1_cs)
            ti1_data <= cpu_dout;
        if (tidata2_cs)
            ti2_data <= cpu_dout;
    end

    kicker_psg u_ti1 (
        .clk    (clk),
        .rst    (rst),
        .clk_en (ti1_cen),
        .wr     (ti1_cs),
        .din    (ti1_data),
        .sound  (ti1_snd)
    );

    kicker_psg u_ti2 (
        .clk    (clk),
        .rst    (rst),
        .clk_en (ti2_cen),
        .wr     (ti2_cs),
        .din    (ti2_data),
        .sound  (ti2_snd)
    );

    assign sum = mix_w'(ti1_snd) + mix_w'(ti2_snd); // sign extended

    // 1.5 gain cannot overflow 16 bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            snd <= '0;
        else if (ti1_cen)
            snd <= mix_w'((sum * mix_gain_num) >>> mix_gain_shift);
    end

    assign sample = ti1_cen;

endmodule

`default_nettype wire

/* design/kicker_main.sv */
/* kicker main board glue
   decoder, read-back, interrupt control and sound */
`timescale 1ns/1ns
`default_nettype none

module kicker_main (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 cpu_cen,
    input  wire                                 ti1_cen,
    input  wire                                 ti2_cen,
    // CPU bus
    input  wire [kicker_pkg::addr_w-1:0]        addr,
    input  wire                                 rnw,
    input  wire                                 vma,
    input  wire [kicker_pkg::data_w-1:0]        cpu_dout,
    output logic [kicker_pkg::data_w-1:0]       cpu_din,
    output logic                                irq_n,
    output logic                                nmi_n,
    // ROM and video
    output logic                                rom_cs,
    input  wire [kicker_pkg::data_w-1:0]        rom_data,
    output logic                                vscr_cs,
    output logic                                vram_cs,
    output logic                                obj1_cs,
    output logic                                obj2_cs,
    input  wire [kicker_pkg::data_w-1:0]        vram_dout,
    input  wire [kicker_pkg::data_w-1:0]        vscr_dout,
    input  wire [kicker_pkg::data_w-1:0]        obj_dout,
    output logic [2:0]                          pal_sel,
    output logic                                flip,
    input  wire                                 lvbl,
    input  wire                                 v16,
    // cabinet
    input  wire [1:0]                           start_button,
    input  wire [1:0]                           coin_input,
    input  wire [5:0]                           joystick1,
    input  wire [5:0]                           joystick2,
    input  wire                                 service,
    input  wire                                 dip_pause,
    input  wire [kicker_pkg::data_w-1:0]        dipsw_a,
    input  wire [kicker_pkg::data_w-1:0]        dipsw_b,
    input  wire [3:0]                           dipsw_c,
    // sound
    output logic signed [kicker_pkg::mix_w-1:0] snd,
    output logic                                sample
);

    logic iow_cs, intshow_cs, ti1_cs, ti2_cs;
    logic dip2_cs, dip3_cs, ior_cs;
    logic tidata1_cs, tidata2_cs, color_cs;

    kicker_decode u_decode (
        .addr       (addr),
        .rnw        (rnw),
        .vma        (vma),
        .rom_cs     (rom_cs),
        .iow_cs     (iow_cs),
        .intshow_cs (intshow_cs),
        .ti1_cs     (ti1_cs),
        .ti2_cs     (ti2_cs),
        .dip2_cs    (dip2_cs),
        .dip3_cs    (dip3_cs),
        .ior_cs     (ior_cs),
        .tidata1_cs (tidata1_cs),
        .tidata2_cs (tidata2_cs),
        .color_cs   (color_cs),
        .vscr_cs    (vscr_cs),
        .obj1_cs    (obj1_cs),
        .obj2_cs    (obj2_cs),
        .vram_cs    (vram_cs)
    );

    kicker_readback u_readback (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr[1:0]),
        .rom_cs       (rom_cs),
        .vram_cs      (vram_cs),
        .intshow_cs   (intshow_cs),
        .obj1_cs      (obj1_cs),
        .obj2_cs      (obj2_cs),
        .ior_cs       (ior_cs),
        .dip2_cs      (dip2_cs),
        .dip3_cs      (dip3_cs),
        .rom_data     (rom_data),
        .vram_dout    (vram_dout),
        .vscr_dout    (vscr_dout),
        .obj_dout     (obj_dout),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .cpu_din      (cpu_din)
    );

    kicker_irq u_irq (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .rnw       (rnw),
        .iow_cs    (iow_cs),
        .color_cs  (color_cs),
        .cpu_dout  (cpu_dout),
        .lvbl      (lvbl),
        .v16       (v16),
        .dip_pause (dip_pause),
        .flip      (flip),
        .pal_sel   (pal_sel),
        .irq_n     (irq_n),
        .nmi_n     (nmi_n)
    );

    kicker_sound u_sound (
        .clk        (clk),
        .rst        (rst),
        .ti1_cen    (ti1_cen),
        .ti2_cen    (ti2_cen),
        .ti1_cs     (ti1_cs),
        .ti2_cs     (ti2_cs),
        .tidata1_cs (tidata1_cs),
        .tidata2_cs (tidata2_cs),
        .cpu_dout   (cpu_dout),
        .snd        (snd),
        .sample     (sample)
    );

endmodule

`default_nettype wire

/* tests/kicker_assertions.sv */
/* kicker bound checks
   select decoding, interrupt clear, read data and sample strobe */
`timescale 1ns/1ns
`default_nettype none

module kicker_assertions (
    input wire        clk,
    input wire        rst,
    input wire [14:0] selects,
    input wire        irq_n,
    input wire        irq_clrn,
    input wire [7:0]  cpu_din,
    input wire        sample,
    input wire        ti1_cen
);

    int failures = 0; // failed assertion count

    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(selects))
        else begin
            failures++;
            $error("more than one chip select high: %b", selects);
        end

    // clear bit low forces irq_n high from the next clock on
    irq_cleared: assert property (@(posedge clk) disable iff (rst) !irq_clrn |=> irq_n)
        else begin
            failures++;
            $error("irq_n low while the irq clear bit is 0");
        end

    din_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(cpu_din))
        else begin
            failures++;
            $error("cpu_din has unknown bits");
        end

    sample_strobe: assert property (@(posedge clk) sample == ti1_cen)
        else begin
            failures++;
            $error("sample differs from ti1_cen");
        end

endmodule

`default_nettype wire

/* tests/kicker_tb.sv */
/* kicker testbench
   replays bus patterns from a file against the board glue */
`timescale 1ns/1ns
`default_nettype none

module kicker_tb;

    logic               clk;
    logic               rst;
    logic               cpu_cen, ti1_cen, ti2_cen;
    logic [15:0]        addr;
    logic               rnw, vma;
    logic [7:0]         cpu_dout, cpu_din;
    logic               irq_n, nmi_n;
    logic               rom_cs, vscr_cs, vram_cs, obj1_cs, obj2_cs;
    logic [7:0]         rom_data, vram_dout, vscr_dout, obj_dout;
    logic [2:0]         pal_sel;
    logic               flip, lvbl, v16;
    logic [1:0]         start_button, coin_input;
    logic [5:0]         joystick1, joystick2;
    logic               service, dip_pause;
    logic [7:0]         dipsw_a, dipsw_b;
    logic [3:0]         dipsw_c;
    logic signed [15:0] snd;
    logic               sample;

    logic [1:0]  cen_phase;
    logic [31:0] rng;
    string       steps[$];
    string       cur_test;
    int          checks, errors, test_checks, test_errors, n_tests;
    int          watchdog_clocks;
    bit          steps_loaded;

    kicker_main UUT (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .ti1_cen(ti1_cen), .ti2_cen(ti2_cen),
        .addr(addr), .rnw(rnw), .vma(vma), .cpu_dout(cpu_dout), .cpu_din(cpu_din),
        .irq_n(irq_n), .nmi_n(nmi_n), .rom_cs(rom_cs), .rom_data(rom_data),
        .vscr_cs(vscr_cs), .vram_cs(vram_cs), .obj1_cs(obj1_cs), .obj2_cs(obj2_cs),
        .vram_dout(vram_dout), .vscr_dout(vscr_dout), .obj_dout(obj_dout),
        .pal_sel(pal_sel), .flip(flip), .lvbl(lvbl), .v16(v16),
        .start_button(start_button), .coin_input(coin_input),
        .joystick1(joystick1), .joystick2(joystick2), .service(service),
        .dip_pause(dip_pause), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .snd(snd), .sample(sample)
    );

    bind kicker_main kicker_assertions u_assertions (
        .clk      (clk),
        .rst      (rst),
        .selects  ({rom_cs, iow_cs, intshow_cs, ti1_cs, ti2_cs, dip2_cs, dip3_cs, ior_cs,
                    tidata1_cs, tidata2_cs, color_cs, vscr_cs, obj1_cs, obj2_cs, vram_cs}),
        .irq_n    (irq_n),
        .irq_clrn (u_irq.irq_clrn),
        .cpu_din  (cpu_din),
        .sample   (sample),
        .ti1_cen  (ti1_cen)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // chip enables every fourth clock, chip 2 offset by two
    always @(posedge clk) begin
        cen_phase <= cen_phase + 2'd1;
        ti1_cen   <= (cen_phase == 2'd3);
        ti2_cen   <= (cen_phase == 2'd1);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // {rom, vram, vscr, obj1, obj2} from the memory map
    function automatic logic [4:0] expected_selects(input logic [15:0] a, input logic rd,
                                                    input logic v);
        if (!v)
            return 5'h00;
        if (a >= 16'h4000)
            return rd ? 5'h10 : 5'h00;
        if (a >= 16'h3800)
            return 5'h08;
        if (a >= 16'h3000)
            return 5'h02;
        if (a >= 16'h2800)
            return 5'h01;
        if (a >= 16'h2000)
            return 5'h04;
        return 5'h00;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        test_checks++;
        assert (actual === expected) else begin
            $display("Error %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test();
        if (cur_test.len() > 0) begin
            $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
            n_tests++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic bus_idle();
        vma <= 1'b0;
        rnw <= 1'b1;
    endtask

    // held four clocks so a chip enable always falls inside
    task automatic do_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr     <= a;
        rnw      <= 1'b0;
        vma      <= 1'b1;
        cpu_dout <= d;
        repeat (4) @(posedge clk);
        bus_idle();
    endtask

    task automatic do_read(input logic [15:0] a, input logic [7:0] e);
        @(posedge clk);
        addr     <= a;
        rnw      <= 1'b1;
        vma      <= 1'b1;
        cpu_dout <= 8'h00; // CPU drives no data on reads
        @(posedge clk);
        bus_idle();
        @(negedge clk);
        compare_value($sformatf("read %04h", a), e, cpu_din);
    endtask

    task automatic check_select(input logic [15:0] a, input logic rd, input logic v,
                                input logic [4:0] e);
        @(posedge clk);
        addr <= a;
        rnw  <= rd;
        vma  <= v;
        @(negedge clk);
        compare_value($sformatf("selects at %04h rnw %b vma %b", a, rd, v), e,
                      {rom_cs, vram_cs, vscr_cs, obj1_cs, obj2_cs});
        @(posedge clk);
        bus_idle();
    endtask

    task automatic random_selects(input int count);
        logic [15:0] a;
        for (int i = 0; i < count; i++) begin
            rng = xorshift32(rng);
            a   = rng[15:0];
            if (!rng[16] || a[15:11] == 5'd0)
                a[15] = 1'b1; // no writes and no sound chip strobes
            check_select(a, rng[16], rng[17], expected_selects(a, rng[16], rng[17]));
        end
    endtask

    task automatic drive_input(input string name, input logic [31:0] v);
        @(posedge clk);
        case (name)
            "lvbl":         lvbl         <= v[0];
            "v16":          v16          <= v[0];
            "dip_pause":    dip_pause    <= v[0];
            "cpu_cen":      cpu_cen      <= v[0];
            "service":      service      <= v[0];
            "start_button": start_button <= v[1:0];
            "coin_input":   coin_input   <= v[1:0];
            "joystick1":    joystick1    <= v[5:0];
            "joystick2":    joystick2    <= v[5:0];
            "dipsw_a":      dipsw_a      <= v[7:0];
            "dipsw_b":      dipsw_b      <= v[7:0];
            "dipsw_c":      dipsw_c      <= v[3:0];
            "rom_data":     rom_data     <= v[7:0];
            "vram_dout":    vram_dout    <= v[7:0];
            "vscr_dout":    vscr_dout    <= v[7:0];
            "obj_dout":     obj_dout     <= v[7:0];
            default:        report_failure({"unknown input name ", name});
        endcase
    endtask

    task automatic check_output(input string name, input logic [31:0] e);
        @(posedge clk);
        @(negedge clk);
        case (name)
            "flip":    compare_value(name, e, {31'd0, flip});
            "pal_sel": compare_value(name, e, {29'd0, pal_sel});
            "irq_n":   compare_value(name, e, {31'd0, irq_n});
            "nmi_n":   compare_value(name, e, {31'd0, nmi_n});
            "cpu_din": compare_value(name, e, {24'd0, cpu_din});
            "snd":     compare_value(name, e, {16'd0, snd[15:0]});
            default:   report_failure({"unknown output name ", name});
        endcase
    endtask

    // skips two sign flips, then times two half periods in chip enables
    task automatic measure_tone(input int p, input logic [15:0] level);
        logic [15:0] last, h1, h2, neg_level;
        int          flips, enables, e1, e2, guard, limit;
        limit     = 4 * (1024 + 3 * p) + 64;
        neg_level = -level;
        last      = snd;
        flips     = 0;
        enables   = 0;
        guard     = 0;
        while (flips < 4 && guard < limit) begin
            @(negedge clk);
            guard++;
            if (snd !== last) begin
                if (last != 16'd0 && snd == -last) begin
                    flips++;
                    if (flips == 3) begin
                        h1 = last;
                        e1 = enables;
                    end else if (flips == 4) begin
                        h2 = last;
                        e2 = enables;
                    end
                end
                enables = 0;
                last    = snd;
            end
            if (ti1_cen)
                enables++;
        end
        if (flips < 4) begin
            report_failure($sformatf("snd did not flip sign four times within %0d clocks",
                                     limit));
        end else begin
            compare_value("first half period in enables", p, e1);
            compare_value("second half period in enables", p, e2);
            compare_value("high level", level, h1[15] ? h2 : h1);
            compare_value("low level", neg_level, h1[15] ? h1 : h2);
        end
    endtask

    task automatic run_step(input string line);
        string       tag, op, tok, dstr, estr;
        logic [31:0] aval, dval, eval;
        aval = 0;
        dval = 0;
        eval = 0;
        void'($sscanf(line, "%s %s %s %s %s", tag, op, tok, dstr, estr));
        void'($sscanf(tok, "%h", aval));
        void'($sscanf(dstr, "%h", dval));
        void'($sscanf(estr, "%h", eval));
        if (tag != cur_test) begin
            finish_test();
            cur_test = tag;
        end
        case (op)
            "wr":    do_write(aval[15:0], dval[7:0]);
            "rd":    do_read(aval[15:0], eval[7:0]);
            "sel":   check_select(aval[15:0], dval[0], 1'b1, eval[4:0]);
            "rsel":  random_selects(aval);
            "trig":  drive_input(tok, dval);
            "out":   check_output(tok, eval);
            "tone":  measure_tone(aval, eval[15:0]);
            default: report_failure({"unknown operation ", op});
        endcase
    endtask

    initial begin
        int    fd;
        int    r;
        string line, t1, t2, t3, t4, t5;
        // every DUT input starts defined
        rst = 1'b1;
        cpu_cen = 1'b1;
        ti1_cen = 1'b0;
        ti2_cen = 1'b0;
        cen_phase = 2'd0;
        addr = 16'h0000;
        rnw = 1'b1;
        vma = 1'b0;
        cpu_dout = 8'h00;
        rom_data = 8'h00;
        vram_dout = 8'h00;
        vscr_dout = 8'h00;
        obj_dout = 8'h00;
        lvbl = 1'b1;
        v16 = 1'b0;
        dip_pause = 1'b0;
        start_button = 2'b11;
        coin_input = 2'b11;
        joystick1 = 6'h3f;
        joystick2 = 6'h3f;
        service = 1'b1;
        dipsw_a = 8'hff;
        dipsw_b = 8'hff;
        dipsw_c = 4'hf;
        rng = 32'hd10a;
        cur_test = "";
        fd = $fopen("tests/kicker_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open tests/kicker_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (r > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%s %s %s %s %s", t1, t2, t3, t4, t5) == 5)
                    steps.push_back(line);
            end
            $fclose(fd);
        end
        watchdog_clocks = (steps.size() + 1) * 2000;
        steps_loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        foreach (steps[i])
            run_step(steps[i]);
        finish_test();
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, checks, errors, UUT.u_assertions.failures);
        if (errors == 0 && UUT.u_assertions.failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        wait (steps_loaded);
        repeat (watchdog_clocks) @(posedge clk);
        $display("watchdog expired after %0d clocks, the run did not finish",
                 watchdog_clocks);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/kicker_pkg.sv
design/kicker_decode.sv
design/kicker_readback.sv
design/kicker_irq.sv
design/kicker_psg.sv
design/kicker_sound.sv
design/kicker_main.sv
tests/kicker_assertions.sv
tests/kicker_tb.sv

/* tests/kicker_patterns.txt */
# tag op addr_or_signal data expected, hex values, - where unused
# sel: data is rnw, expected is {rom,vram,vscr,obj1,obj2}; tone: period and level
reset out irq_n - 1
reset out nmi_n - 1
reset out cpu_din - ff
reset out flip - 0
reset out pal_sel - 0
reset out snd - 0
decode sel 2000 1 04
decode sel 2800 1 01
decode sel 3000 1 02
decode sel 3fff 0 08
decode sel 4000 1 10
decode sel 4000 0 00
decode sel ffff 1 10
decode sel 0700 1 00
decode rsel 40 - -
readback trig start_button 1 -
readback trig coin_input 2 -
readback trig service 0 -
readback trig joystick1 2d -
readback trig joystick2 12 -
readback trig dipsw_a 5a -
readback trig dipsw_b c3 -
readback trig dipsw_c 6 -
readback trig rom_data a5 -
readback trig vram_dout 3c -
readback trig vscr_dout 71 -
readback trig obj_dout 0f -
readback rd 0700 - ea
readback rd 0701 - ee
readback rd 0702 - d1
readback rd 0703 - 5a
readback rd 0500 - c3
readback rd 0600 - f6
readback rd 0200 - 71
readback rd 3000 - 0f
readback rd 2800 - 0f
readback rd 3800 - 3c
readback rd 8000 - a5
readback rd 2000 - ff
readback rd 0100 - ff
control wr 0000 01 -
control out flip - 1
control wr 1800 05 -
control out pal_sel - 5
control rd 0000 - ff
control rd 1800 - ff
control out flip - 1
control out pal_sel - 5
control trig cpu_cen 0 -
control wr 0000 00 -
control wr 1800 02 -
control out flip - 1
control out pal_sel - 5
control trig cpu_cen 1 -
control wr 0000 00 -
control out flip - 0
irq trig dip_pause 1 -
irq wr 0000 06 -
irq out nmi_n - 1
irq out irq_n - 1
irq trig v16 1 -
irq out nmi_n - 0
irq trig v16 0 -
irq out nmi_n - 0
irq wr 0000 04 -
irq out nmi_n - 1
irq trig lvbl 0 -
irq out irq_n - 0
irq trig lvbl 1 -
irq out irq_n - 0
irq wr 0000 02 -
irq out irq_n - 1
irq wr 0000 06 -
irq trig dip_pause 0 -
irq trig lvbl 0 -
irq out irq_n - 1
tone wr 1000 95 -
tone wr 0400 00 -
tone wr 1000 83 -
tone wr 0400 00 -
tone wr 1000 01 -
tone wr 0400 00 -
tone tone 13 - 1e0
